/* Makefile */
LOG := sim.log

.PHONY: all build lint clean

all: build
	./obj_dir/Vupsampler_tb | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

build:
	verilator --binary --timing --assert -f build.f --top-module upsampler_tb

lint:
	verilator --lint-only --timing -f build.f --top-module upsampler_stereo

clean:
	rm -rf obj_dir $(LOG)

/* build.f */
+incdir+src
src/rsmp_pkg.sv
src/coef_rom.sv
src/sample_ringbuf.sv
src/pipelined_mult.sv
src/shared_path_arbiter.sv
src/channel_resampler.sv
src/upsampler_stereo.sv
verification/tb_clock.sv
verification/upsampler_tb.sv

/* src/channel_resampler.sv */
`default_nettype none

`include "rsmp_consts.svh"

module channel_resampler (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 gnt_i,
    output logic                 req_o,
    output rsmp_pkg::bank_addr_t bank_addr_o,
    input  rsmp_pkg::coef_t      coef_i,
    output rsmp_pkg::sample_t    mpcand_o,
    output rsmp_pkg::coef_t      mplier_o,
    input  rsmp_pkg::sample_t    mprod_i,
    output logic                 ring_pop_o,
    output rsmp_pkg::tap_t       ring_offset_o,
    input  rsmp_pkg::sample_t    ring_data_i,
    input  logic                 out_pop_i,
    output rsmp_pkg::sample_t    out_data_o,
    output logic                 out_ack_o
);

    localparam int CNT_W = `RSMP_TAPS_LOG2 + 1;
    // address, operand register, then the multiplier
    localparam logic [CNT_W-1:0] ACC_FIRST = CNT_W'(`RSMP_MULT_LAT + 2);
    localparam logic [CNT_W-1:0] CALC_LAST = CNT_W'(`RSMP_TAPS + `RSMP_MULT_LAT + 1);

    rsmp_pkg::res_state_t state_q;

    logic [CNT_W-1:0] calc_cnt_q;
    logic             phase_q;
    logic [1:0]       phase_cnt_q;
    logic [2:0]       phase_cnt_sum;
    logic             phase_wrap;
    logic             pend_q;

    rsmp_pkg::sample_t sample_q;
    rsmp_pkg::coef_t   coef_q;
    rsmp_pkg::acc_t    acc_q;
    rsmp_pkg::sample_t result_q;

    function automatic rsmp_pkg::sample_t saturate(input rsmp_pkg::acc_t sum);
        if (sum > 26'sh7fffff) begin
            return 24'sh7fffff;
        end else if (sum < -26'sh7fffff) begin
            return -24'sh7fffff;
        end
        return sum[23:0];
    endfunction

    // release one input sample once the counter wraps
    assign phase_cnt_sum = {1'b0, phase_cnt_q} + 3'(`RSMP_DECIM);
    assign phase_wrap    = phase_cnt_sum >= 3'(`RSMP_PHASES);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= rsmp_pkg::RS_IDLE;
            calc_cnt_q  <= '0;
            phase_q     <= 1'b0;
            phase_cnt_q <= '0;
            pend_q      <= 1'b0;
            result_q    <= '0;
        end else begin
            case (state_q)
                rsmp_pkg::RS_IDLE: begin
                    if (out_pop_i || pend_q) begin
                        state_q <= rsmp_pkg::RS_RESULT;
                        pend_q  <= 1'b0;
                    end
                end
                rsmp_pkg::RS_RESULT: begin
                    calc_cnt_q <= '0;
                    state_q    <= gnt_i ? rsmp_pkg::RS_CALC : rsmp_pkg::RS_WAIT_GRANT;
                end
                rsmp_pkg::RS_WAIT_GRANT: begin
                    if (gnt_i) begin
                        state_q <= rsmp_pkg::RS_CALC;
                    end
                end
                rsmp_pkg::RS_CALC: begin
                    if (calc_cnt_q == CALC_LAST) begin
                        state_q <= rsmp_pkg::RS_NEXT_PHASE;
                    end else begin
                        calc_cnt_q <= calc_cnt_q + 1'b1;
                    end
                end
                rsmp_pkg::RS_NEXT_PHASE: begin
                    result_q    <= saturate(acc_q);
                    phase_q     <= ~phase_q;
                    phase_cnt_q <= phase_wrap ? 2'(phase_cnt_sum - 3'(`RSMP_PHASES))
                                              : phase_cnt_sum[1:0];
                    state_q     <= rsmp_pkg::RS_IDLE;
                end
                default: begin
                    state_q <= rsmp_pkg::RS_IDLE;
                end
            endcase
            // a pop while busy is kept for later
            if (out_pop_i && state_q != rsmp_pkg::RS_IDLE) begin
                pend_q <= 1'b1;
            end
        end
    end

    // stage 1 operands and stage 6 accumulate
    always_ff @(posedge clk) begin
        if (state_q == rsmp_pkg::RS_CALC) begin
            sample_q <= ring_data_i;
            coef_q   <= coef_i;
        end
        if (state_q == rsmp_pkg::RS_RESULT) begin
            acc_q <= '0;
        end else if (state_q == rsmp_pkg::RS_CALC && calc_cnt_q >= ACC_FIRST) begin
            acc_q <= acc_q + rsmp_pkg::acc_t'(mprod_i);
        end
    end

    // stage 0 addresses
    assign bank_addr_o   = {phase_q, calc_cnt_q[`RSMP_TAPS_LOG2-1:0]};
    assign ring_offset_o = calc_cnt_q[`RSMP_TAPS_LOG2-1:0];

    assign mpcand_o = sample_q;
    assign mplier_o = coef_q;

    assign req_o = (state_q == rsmp_pkg::RS_RESULT)
                || (state_q == rsmp_pkg::RS_WAIT_GRANT)
                || (state_q == rsmp_pkg::RS_CALC);

    assign ring_pop_o = (state_q == rsmp_pkg::RS_NEXT_PHASE) && phase_wrap;

    assign out_ack_o  = (state_q == rsmp_pkg::RS_RESULT);
    assign out_data_o = out_ack_o ? result_q : '0;

endmodule

`default_nettype wire

/* src/coef_bank.hex */
// q15 coefficients, one per line: phase 0 taps 0..31, then phase 1 taps 0..31
fff0
ffe0
ffc8
ffb0
ffa0
ffc0
0000
00a0
0180
0300
0500
0780
0a00
0c80
0e80
0f80
0f80
0e80
0c80
0a00
0780
0500
0300
0180
00a0
0000
ffc0
ffa0
ffb0
ffc8
ffe0
fff0
fff8
ffe8
ffd0
ffb8
ffa8
ffb0
ffe0
0040
0100
0240
0400
0640
08c0
0b40
0d80
0f00
1000
0f40
0dc0
0b80
0900
0680
0440
0280
0120
0050
ffd8
ffb4
ffac
ffc4
ffdc
fff4

/* src/coef_rom.sv */
`default_nettype none

`include "rsmp_consts.svh"

module coef_rom (
    input  logic                   clk,
    input  rsmp_pkg::bank_addr_t   addr_i,
    output rsmp_pkg::coef_t        data_o
);

    // phase 0 taps first, then phase 1
    rsmp_pkg::coef_t rom [0:`RSMP_TAPS*`RSMP_PHASES-1];

    initial begin
        $readmemh("src/coef_bank.hex", rom);
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        data_o <= rom[addr_i];
    end

endmodule

`default_nettype wire

/* src/pipelined_mult.sv */
`default_nettype none

`include "rsmp_consts.svh"

module pipelined_mult (
    input  logic              clk,
    input  logic              rst,
    input  rsmp_pkg::sample_t mpcand_i,
    input  rsmp_pkg::coef_t   mplier_i,
    output rsmp_pkg::sample_t mprod_o
);

    logic signed [39:0] product;
    logic signed [39:0] scaled;

    rsmp_pkg::sample_t pipe_q [0:`RSMP_MULT_LAT-1];

    // full product, then drop the q15 fraction
    assign product = mpcand_i * mplier_i;
    assign scaled  = product >>> 15;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RSMP_MULT_LAT; i++) begin
                pipe_q[i] <= '0;
            end
        end else begin
            pipe_q[0] <= scaled[23:0];
            for (int i = 1; i < `RSMP_MULT_LAT; i++) begin
                pipe_q[i] <= pipe_q[i-1];
            end
        end
    end

    // no stall, product leaves after a fixed count
    assign mprod_o = pipe_q[`RSMP_MULT_LAT-1];

endmodule

`default_nettype wire

/* src/rsmp_consts.svh */
`ifndef RSMP_CONSTS_SVH
`define RSMP_CONSTS_SVH

// fir taps per phase
`define RSMP_TAPS 32
`define RSMP_TAPS_LOG2 5

// coefficient phases in the bank
`define RSMP_PHASES 2

// phase counter step per result
`define RSMP_DECIM 1

// shared multiplier pipeline depth
`define RSMP_MULT_LAT 4

// per-channel sample ring
`define RSMP_RING_LEN 64
`define RSMP_RING_LEN_LOG2 6

`endif

/* src/rsmp_pkg.sv */
`default_nettype none

`include "rsmp_consts.svh"

package rsmp_pkg;

    // 24-bit signed audio sample
    typedef logic signed [23:0] sample_t;

    // q15 filter coefficient
    typedef logic signed [15:0] coef_t;

    // two guard bits over the sample width
    typedef logic signed [25:0] acc_t;

    // phase bit above the tap index
    typedef logic [`RSMP_TAPS_LOG2:0] bank_addr_t;

    // tap offset from the oldest unreleased sample
    typedef logic [`RSMP_TAPS_LOG2-1:0] tap_t;

    typedef enum logic [2:0] {
        RS_IDLE,
        RS_RESULT,
        RS_WAIT_GRANT,
        RS_CALC,
        RS_NEXT_PHASE
    } res_state_t;

endpackage

`default_nettype wire

/* src/sample_ringbuf.sv */
`default_nettype none

`include "rsmp_consts.svh"

module sample_ringbuf #(
    parameter int LEN_LOG2 = `RSMP_RING_LEN_LOG2
) (
    input  logic              clk,
    input  logic              rst,
    input  rsmp_pkg::sample_t data_i,
    input  logic              we_i,
    input  logic              pop_i,
    input  rsmp_pkg::tap_t    offset_i,
    output rsmp_pkg::sample_t data_o
);

    rsmp_pkg::sample_t mem [0:(1<<LEN_LOG2)-1];

    logic [LEN_LOG2-1:0] wr_ptr_q;
    logic [LEN_LOG2-1:0] rd_ptr_q;
    logic [LEN_LOG2-1:0] rd_addr;

    // offset 0 is the oldest sample not yet released
    assign rd_addr = rd_ptr_q + LEN_LOG2'(offset_i);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (we_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // storage and registered read
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[wr_ptr_q] <= data_i;
        end
        data_o <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* src/shared_path_arbiter.sv */
`default_nettype none

module shared_path_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [1:0]           req_i,
    output logic [1:0]           gnt_o,
    input  rsmp_pkg::bank_addr_t bank_addr_0_i,
    input  rsmp_pkg::bank_addr_t bank_addr_1_i,
    input  rsmp_pkg::sample_t    mpcand_0_i,
    input  rsmp_pkg::sample_t    mpcand_1_i,
    input  rsmp_pkg::coef_t      mplier_0_i,
    input  rsmp_pkg::coef_t      mplier_1_i,
    output rsmp_pkg::bank_addr_t bank_addr_o,
    output rsmp_pkg::sample_t    mpcand_o,
    output rsmp_pkg::coef_t      mplier_o
);

    logic [1:0] gnt_q;
    logic [1:0] gnt_d;
    logic       last_q;
    logic       held;

    // grant stays while its owner keeps requesting
    assign held = |(gnt_q & req_i);

    always_comb begin
        gnt_d = gnt_q;
        if (!held) begin
            gnt_d = 2'b00;
            // the channel that did not win last time goes first
            if (req_i[~last_q]) begin
                gnt_d[~last_q] = 1'b1;
            end else if (req_i[last_q]) begin
                gnt_d[last_q] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            gnt_q  <= 2'b00;
            last_q <= 1'b1;
        end else begin
            gnt_q <= gnt_d;
            if (!held && |gnt_d) begin
                last_q <= gnt_d[1];
            end
        end
    end

    assign gnt_o = gnt_q;

    // shared buses carry only the granted channel
    always_comb begin
        bank_addr_o = '0;
        mpcand_o    = '0;
        mplier_o    = '0;
        case (gnt_q)
            2'b01: begin
                bank_addr_o = bank_addr_0_i;
                mpcand_o    = mpcand_0_i;
                mplier_o    = mplier_0_i;
            end
            2'b10: begin
                bank_addr_o = bank_addr_1_i;
                mpcand_o    = mpcand_1_i;
                mplier_o    = mplier_1_i;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/upsampler_stereo.sv */
`default_nettype none

`include "rsmp_consts.svh"

module upsampler_stereo (
    input  logic              clk,
    input  logic              rst,
    input  rsmp_pkg::sample_t in_data_i,
    input  logic [1:0]        in_we_i,
    output logic [1:0]        in_pop_o,
    input  logic [1:0]        out_pop_i,
    output rsmp_pkg::sample_t out_data_o,
    output logic [1:0]        out_ack_o
);

    logic [1:0] req;
    logic [1:0] gnt;

    rsmp_pkg::bank_addr_t bank_addr_ch [2];
    rsmp_pkg::sample_t    mpcand_ch [2];
    rsmp_pkg::coef_t      mplier_ch [2];
    rsmp_pkg::tap_t       ring_offset [2];
    rsmp_pkg::sample_t    ring_data [2];
    rsmp_pkg::sample_t    data_ch [2];

    // shared rom and multiplier path
    rsmp_pkg::bank_addr_t bank_addr;
    rsmp_pkg::coef_t      coef;
    rsmp_pkg::sample_t    mpcand;
    rsmp_pkg::coef_t      mplier;
    rsmp_pkg::sample_t    mprod;

    // 0 is left, 1 is right
    for (genvar c = 0; c < 2; c++) begin : g_ch
        sample_ringbuf #(
            .LEN_LOG2(`RSMP_RING_LEN_LOG2)
        ) u_ring (
            .clk(clk), .rst(rst),
            .data_i(in_data_i), .we_i(in_we_i[c]),
            .pop_i(in_pop_o[c]), .offset_i(ring_offset[c]), .data_o(ring_data[c])
        );

        channel_resampler u_res (
            .clk(clk), .rst(rst),
            .gnt_i(gnt[c]), .req_o(req[c]),
            .bank_addr_o(bank_addr_ch[c]), .coef_i(coef),
            .mpcand_o(mpcand_ch[c]), .mplier_o(mplier_ch[c]), .mprod_i(mprod),
            .ring_pop_o(in_pop_o[c]), .ring_offset_o(ring_offset[c]),
            .ring_data_i(ring_data[c]),
            .out_pop_i(out_pop_i[c]), .out_data_o(data_ch[c]), .out_ack_o(out_ack_o[c])
        );
    end

    shared_path_arbiter u_arb (
        .clk(clk), .rst(rst),
        .req_i(req), .gnt_o(gnt),
        .bank_addr_0_i(bank_addr_ch[0]), .bank_addr_1_i(bank_addr_ch[1]),
        .mpcand_0_i(mpcand_ch[0]), .mpcand_1_i(mpcand_ch[1]),
        .mplier_0_i(mplier_ch[0]), .mplier_1_i(mplier_ch[1]),
        .bank_addr_o(bank_addr), .mpcand_o(mpcand), .mplier_o(mplier)
    );

    coef_rom u_rom (
        .clk(clk), .addr_i(bank_addr), .data_o(coef)
    );

    pipelined_mult u_mult (
        .clk(clk), .rst(rst),
        .mpcand_i(mpcand), .mplier_i(mplier), .mprod_o(mprod)
    );

    // each channel drives zero outside its ack
    assign out_data_o = data_ch[0] | data_ch[1];

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 4
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

/* verification/upsampler_tb.sv */
`default_nettype none

`include "rsmp_consts.svh"

module upsampler_tb;

    localparam int IMPULSE_POPS = 16;
    localparam int RAND_ROUNDS  = 24;
    localparam int SAT_ROUNDS   = 72;
    // long enough for one channel to wait out the other's whole fir pass
    localparam int GAP          = 90;
    localparam int REFILL_MIN   = 34;
    localparam int PLANNED_POPS = IMPULSE_POPS + 2 * (RAND_ROUNDS + SAT_ROUNDS);
    localparam int TIMEOUT      = PLANNED_POPS * 80 + 1000;

    logic              clk;
    logic              rst;
    rsmp_pkg::sample_t in_data;
    logic [1:0]        in_we;
    logic [1:0]        in_pop;
    logic [1:0]        out_pop;
    rsmp_pkg::sample_t out_data;
    logic [1:0]        out_ack;

    integer            seed;
    logic signed [15:0] coef_mem [0:`RSMP_TAPS*`RSMP_PHASES-1];
    logic signed [23:0] left_q [$];
    logic signed [23:0] right_q [$];
    logic signed [23:0] held [2];
    bit                 sat_expected [2];
    int                 phase [2];
    int                 results [2];
    int                 pops_seen [2];
    int                 data_errors;
    int                 proto_errors;
    int                 sat_hits;
    int                 fill_kind;
    bit                 started;

    tb_clock #(.PERIOD(4)) u_clk (.clk_o(clk));

    upsampler_stereo UUT (
        .clk(clk), .rst(rst),
        .in_data_i(in_data), .in_we_i(in_we), .in_pop_o(in_pop),
        .out_pop_i(out_pop), .out_data_o(out_data), .out_ack_o(out_ack)
    );

    // a pop to an idle channel is acked in the next cycle
    for (genvar c = 0; c < 2; c++) begin : g_ack
        assert property (@(posedge clk) disable iff (rst) out_pop[c] |=> out_ack[c])
        else begin
            proto_errors++;
            $display("t=%0t: channel %0d did not ack its pop in the next cycle", $time, c);
        end
    end

    // sampled away from the clock edge
    always @(negedge clk) begin
        if (!rst) begin
            for (int c = 0; c < 2; c++) begin
                if (in_pop[c]) begin
                    pops_seen[c]++;
                end
            end
            if (!started) begin
                assert (out_ack == 2'b00 && in_pop == 2'b00)
                else begin
                    proto_errors++;
                    $display("t=%0t: ack or ring pop seen before any output request", $time);
                end
            end
        end
    end

    initial begin
        repeat (TIMEOUT) @(posedge clk);
        $display("watchdog: the run did not finish within %0d cycles", TIMEOUT);
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic signed [23:0] front_sample(int ch, int k);
        return (ch == 0) ? left_q[k] : right_q[k];
    endfunction

    function automatic logic signed [23:0] full_value(int ch);
        return (ch == 0) ? 24'sh7fffff : 24'sh800000;
    endfunction

    function automatic int queue_size(int ch);
        return (ch == 0) ? left_q.size() : right_q.size();
    endfunction

    // sum of per-tap q15 products, then clamp
    function automatic logic signed [23:0] fir_expect(int ch);
        logic signed [47:0] sum;
        logic signed [47:0] prod;
        logic signed [23:0] term;
        sum = '0;
        for (int k = 0; k < `RSMP_TAPS; k++) begin
            prod = front_sample(ch, k) * coef_mem[phase[ch] * `RSMP_TAPS + k];
            prod = prod >>> 15;
            term = prod[23:0];
            sum  = sum + term;
        end
        if (sum > 48'sh7fffff) begin
            return 24'sh7fffff;
        end else if (sum < -48'sh7fffff) begin
            return -24'sh7fffff;
        end
        return sum[23:0];
    endfunction

    task automatic push_sample(int ch, logic signed [23:0] value);
        in_data   = value;
        in_we[ch] = 1'b1;
        @(posedge clk);
        #1;
        in_we = 2'b00;
        if (ch == 0) begin
            left_q.push_back(value);
        end else begin
            right_q.push_back(value);
        end
    endtask

    // 0 zeros, 1 random, 2 full scale
    task automatic refill(int ch);
        logic signed [23:0] value;
        while (queue_size(ch) < REFILL_MIN) begin
            case (fill_kind)
                1: value = $random(seed);
                2: value = full_value(ch);
                default: value = '0;
            endcase
            push_sample(ch, value);
        end
    endtask

    task automatic advance_model(int ch);
        bit all_full;
        all_full = 1'b1;
        for (int k = 0; k < `RSMP_TAPS; k++) begin
            if (front_sample(ch, k) !== full_value(ch)) begin
                all_full = 1'b0;
            end
        end
        sat_expected[ch] = all_full;
        held[ch] = fir_expect(ch);
        results[ch]++;
        if (phase[ch] == 1) begin
            if (ch == 0) begin
                void'(left_q.pop_front());
            end else begin
                void'(right_q.pop_front());
            end
        end
        phase[ch] = 1 - phase[ch];
    endtask

    // called one time unit into the ack cycle
    task automatic check_ack(int ch);
        logic signed [23:0] sat_value;
        sat_value = (ch == 0) ? 24'sh7fffff : -24'sh7fffff;
        assert (out_ack[1-ch] === 1'b0)
        else begin
            proto_errors++;
            $display("t=%0t: channel %0d acked without being asked", $time, 1 - ch);
        end
        assert (out_data === held[ch])
        else begin
            data_errors++;
            $display("CHECK FAILED t=%0t out_data_o (channel %0d) expected %h got %h",
                     $time, ch, held[ch], out_data);
        end
        if (sat_expected[ch]) begin
            sat_hits++;
            assert (out_data === sat_value)
            else begin
                data_errors++;
                $display("CHECK FAILED t=%0t out_data_o (channel %0d sat) expected %h got %h",
                         $time, ch, sat_value, out_data);
            end
        end
        advance_model(ch);
    endtask

    task automatic pop_one(int ch);
        started     = 1'b1;
        out_pop[ch] = 1'b1;
        @(posedge clk);
        #1;
        out_pop[ch] = 1'b0;
        check_ack(ch);
    endtask

    // second pop lands while the first channel computes
    task automatic pop_staggered(int a, int b);
        started    = 1'b1;
        out_pop[a] = 1'b1;
        @(posedge clk);
        #1;
        out_pop[a] = 1'b0;
        out_pop[b] = 1'b1;
        check_ack(a);
        @(posedge clk);
        #1;
        out_pop[b] = 1'b0;
        check_ack(b);
    endtask

    task automatic settle();
        repeat (GAP) @(posedge clk);
        #1;
        for (int c = 0; c < 2; c++) begin
            assert (pops_seen[c] == results[c] / 2)
            else begin
                data_errors++;
                $display("CHECK FAILED t=%0t in_pop_o[%0d] count expected %0d got %0d",
                         $time, c, results[c] / 2, pops_seen[c]);
            end
        end
    endtask

    initial begin
        seed         = 32'he5db_c7c9;
        rst          = 1'b1;
        in_data      = '0;
        in_we        = 2'b00;
        out_pop      = 2'b00;
        data_errors  = 0;
        proto_errors = 0;
        sat_hits     = 0;
        started      = 1'b0;
        fill_kind    = 0;
        for (int c = 0; c < 2; c++) begin
            held[c]         = '0;
            phase[c]        = 0;
            results[c]      = 0;
            pops_seen[c]    = 0;
            sat_expected[c] = 1'b0;
        end
        $readmemh("src/coef_bank.hex", coef_mem);
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (10) @(posedge clk);
        #1;

        // impulse at tap 31 on the left, random on the right
        for (int i = 0; i < `RSMP_TAPS - 1; i++) begin
            push_sample(0, '0);
        end
        push_sample(0, 24'sh400000);
        refill(0);
        fill_kind = 1;
        refill(1);
        fill_kind = 0;
        for (int i = 0; i < IMPULSE_POPS; i++) begin
            refill(0);
            pop_one(0);
            settle();
        end

        fill_kind = 1;
        for (int i = 0; i < RAND_ROUNDS; i++) begin
            refill(0);
            refill(1);
            if (i % 2 == 0) begin
                pop_staggered(0, 1);
            end else begin
                pop_staggered(1, 0);
            end
            settle();
        end

        // old samples drain out until only full scale is left
        fill_kind = 2;
        for (int i = 0; i < SAT_ROUNDS; i++) begin
            refill(0);
            refill(1);
            pop_staggered(i % 2, 1 - i % 2);
            settle();
        end

        assert (sat_hits > 0)
        else begin
            proto_errors++;
            $display("the saturation case was never reached");
        end
        $display("errors: data %0d, protocol %0d", data_errors, proto_errors);
        if (data_errors + proto_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
